//--- include/sys1_settings.svh
//##########################################################
// shared constants for the system-1 input side
// download address width, graphics window, reset game code
//##########################################################

`ifndef SYS1_SETTINGS_SVH
`define SYS1_SETTINGS_SVH

// download bus byte address width
`define SYS1_ADDR_W 25

// graphics window runs from zero up to here
// everything above it is program, sound and prom space
`define SYS1_GFX_TOP 'h3FFFFF

// slapstic/game code held until the host sends index 1
// 105 selects indiana jones
`define SYS1_RESET_GAME 105

`endif

//--- verilog/sys1_rom_pkg.sv
//##########################################################
// rom download types
// region codes, word and word-address types
//##########################################################

package sys1_rom_pkg;

	// one code per download region
	typedef enum logic [3:0]
	{
		GFX,
		PROG0,
		PROG1,
		PROG2,
		PROG5,
		PROG6,
		PROG7,
		SLAP,
		SND0,
		SND1,
		SND2,
		ALPHA,
		COLOR,
		REMAP,
		EEPROM,
		NONE
	} rom_region_e;

	// full write word, gfx is 8 bytes wide
	typedef logic [63:0] rom_word_t;

	// word address, wide enough for 0x80000 gfx words
	typedef logic [18:0] rom_addr_t;

	// bytes gathered per write, zero for unmapped space
	function automatic logic [3:0] word_bytes(rom_region_e r);
		case (r)
		GFX:                                           word_bytes = 4'd8;
		PROG0, PROG1, PROG2, PROG5, PROG6, PROG7, SLAP: word_bytes = 4'd2;
		NONE:                                          word_bytes = 4'd0;
		default:                                       word_bytes = 4'd1;
		endcase
	endfunction

endpackage

//--- verilog/sys1_ctrl_pkg.sv
//##########################################################
// player control types
// game codes, held-key state, direction vector
//##########################################################

package sys1_ctrl_pkg;

	// slapstic type as loaded from download index 1
	typedef enum logic [7:0]
	{
		MARBLE   = 8'd103,
		INDY     = 8'd105,
		PETERPAK = 8'd107,
		ROADRUN  = 8'd108,
		ROADB109 = 8'd109,
		ROADB110 = 8'd110
	} game_e;

	// held keys from the keyboard, all active high
	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		// act0 is jump, act1 is whip/start
		logic act0;
		logic act1;
		logic coin_l;
		logic coin_r;
		logic coin_aux;
		// unused slot, stays low
		logic spare;
	} key_state_t;

	// up, down, left, right from msb to lsb
	// same order as joystick bits 3:0
	typedef logic [3:0] ctrl_dir_t;

endpackage

//--- verilog/rom_loader.sv
//##########################################################
// rom download router
// region decode, byte accumulator, one write per word
//##########################################################
`timescale 1ns/1ns
`include "sys1_settings.svh"

module rom_loader
(
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  logic [7:0]                ioctl_index,
	input  logic [`SYS1_ADDR_W-1:0]   ioctl_addr,
	input  logic [7:0]                ioctl_dout,
	input  logic                      rom_ready,
	output logic                      ioctl_wait,
	output logic                      rom_wr,
	output sys1_rom_pkg::rom_region_e rom_region,
	output sys1_rom_pkg::rom_addr_t   rom_addr,
	output sys1_rom_pkg::rom_word_t   rom_data
);
	import sys1_rom_pkg::*;

	logic [55:0] acc;
	rom_region_e region;
	rom_addr_t   waddr;
	rom_word_t   wdata;
	logic        word_done;
	logic        accept;

	// host stalls while the sink is busy
	assign ioctl_wait = ~rom_ready;
	// index 0 carries the rom set
	assign accept = ioctl_download & ioctl_wr & (ioctl_index == 8'd0) & rom_ready;

	//##########################################################
	// address decode
	//##########################################################
	always_comb
	begin
		region = NONE;
		if (ioctl_addr <= `SYS1_GFX_TOP)
			region = GFX;
		// 16k and 32k program banks
		else if (ioctl_addr[24:14] == 11'h100)
			region = PROG0;
		else if (ioctl_addr[24:15] == 10'h082)
			region = PROG1;
		else if (ioctl_addr[24:15] == 10'h084)
			region = PROG2;
		else if (ioctl_addr[24:15] == 10'h08A)
			region = PROG5;
		else if (ioctl_addr[24:15] == 10'h08C)
			region = PROG6;
		else if (ioctl_addr[24:15] == 10'h08E)
			region = PROG7;
		else if (ioctl_addr[24:14] == 11'h120)
			region = SLAP;
		// byte wide sound and alpha roms
		else if (ioctl_addr[24:14] == 11'h122)
			region = SND0;
		else if (ioctl_addr[24:14] == 11'h123)
			region = SND1;
		else if (ioctl_addr[24:14] == 11'h124)
			region = SND2;
		else if (ioctl_addr[24:14] == 11'h125)
			region = ALPHA;
		// 512 byte proms
		else if (ioctl_addr[24:9] == 16'h24C0)
			region = COLOR;
		else if (ioctl_addr[24:9] == 16'h24C1)
			region = REMAP;
		else if (ioctl_addr[24:9] == 16'h24C2)
			region = EEPROM;
	end

	// word address, data and completion per word size
	always_comb
	begin
		waddr = '0;
		wdata = '0;
		word_done = 1'b0;
		case (word_bytes(region))
		4'd8:
		begin
			// oldest byte ends up in the top lane
			waddr = ioctl_addr[21:3];
			wdata = {acc, ioctl_dout};
			word_done = (ioctl_addr[2:0] == 3'd7);
		end
		4'd2:
		begin
			waddr = {4'd0, ioctl_addr[15:1]};
			wdata = {48'd0, acc[7:0], ioctl_dout};
			word_done = ioctl_addr[0];
		end
		4'd1:
		begin
			if (region inside {COLOR, REMAP, EEPROM})
				waddr = {10'd0, ioctl_addr[8:0]};
			else
				waddr = {5'd0, ioctl_addr[13:0]};
			wdata = {56'd0, ioctl_dout};
			word_done = 1'b1;
		end
		default:
			word_done = 1'b0;
		endcase
	end

	// last seven bytes and the latched write
	always_ff @(posedge clk_sys)
	begin
		if (accept)
			acc <= {acc[47:0], ioctl_dout};
		if (accept && word_done)
		begin
			rom_region <= region;
			rom_addr <= waddr;
			rom_data <= wdata;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			rom_wr <= 1'b0;
		else
			rom_wr <= accept & word_done;
	end

	// host side handshake rule
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wait |-> !ioctl_wr)
		else $error("ioctl_wr raised while ioctl_wait is high");

	// sink sees a single strobe per word
	a_wr_one_cycle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rom_wr |=> !rom_wr)
		else $error("rom_wr held for two cycles");

endmodule

//--- verilog/game_config.sv
//##########################################################
// game type register
// loaded from download index 1
//##########################################################
`timescale 1ns/1ns
`include "sys1_settings.svh"

module game_config
(
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  logic [7:0]          ioctl_index,
	input  logic [7:0]          ioctl_dout,
	output sys1_ctrl_pkg::game_e game_type
);
	import sys1_ctrl_pkg::*;

	logic cfg_wr;

	// one byte on index 1 picks the game
	assign cfg_wr = ioctl_download & ioctl_wr & (ioctl_index == 8'd1);

	// unknown codes kept as sent, mapper falls back to defaults
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			game_type <= game_e'(8'(`SYS1_RESET_GAME));
		else if (cfg_wr)
			game_type <= game_e'(ioctl_dout);
	end

endmodule

//--- verilog/ps2_key_decoder.sv
//##########################################################
// keyboard event decoder
// toggle detect, scancode to held-key state
//##########################################################
`timescale 1ns/1ns

module ps2_key_decoder
(
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic [10:0]               ps2_key,
	output sys1_ctrl_pkg::key_state_t keys
);

	logic       toggle_d;
	logic       key_event;
	logic       pressed;
	logic [8:0] code;

	// bit 10 flips once per event
	assign key_event = (toggle_d != ps2_key[10]);
	assign pressed = ps2_key[9];
	assign code = ps2_key[8:0];

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			toggle_d <= 1'b0;
			keys <= '0;
		end
		else
		begin
			toggle_d <= ps2_key[10];
			if (key_event)
			begin
				case (code)
				// arrow keys, extended codes
				9'h175: keys.up <= pressed;
				9'h172: keys.down <= pressed;
				9'h16B: keys.left <= pressed;
				9'h174: keys.right <= pressed;
				// left ctrl whip, left alt jump
				9'h014: keys.act1 <= pressed;
				9'h011: keys.act0 <= pressed;
				// number row 5, 6, 7
				9'h02E: keys.coin_l <= pressed;
				9'h036: keys.coin_r <= pressed;
				9'h03D: keys.coin_aux <= pressed;
				// anything else leaves state alone
				default: ;
				endcase
			end
		end
	end

endmodule

//--- verilog/control_mapper.sv
//##########################################################
// per-game control mapper
// switches, coins, self test and adc top bits
//##########################################################
`timescale 1ns/1ns

module control_mapper
(
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  sys1_ctrl_pkg::game_e      game_type,
	input  sys1_ctrl_pkg::key_state_t keys,
	input  logic [11:0]               joystick,
	input  logic                      service,
	output logic [4:0]                switches,
	output logic [2:0]                coin_n,
	output logic                      selftest_n,
	output logic [7:0]                adc_bit7,
	output logic [7:0]                adc_bit6
);
	import sys1_ctrl_pkg::*;

	ctrl_dir_t  dir;
	logic       a0;
	logic       a1;
	logic [7:0] inputs;
	logic [4:0] sw_nxt;
	logic [7:0] b7_nxt;
	logic [7:0] b6_nxt;

	// keyboard and joystick merged, active high
	assign dir = {keys.up, keys.down, keys.left, keys.right} | joystick[3:0];
	assign a0 = keys.act0 | joystick[4];
	assign a1 = keys.act1 | joystick[5];
	// indy wants 000udlr0
	assign inputs = (game_type == INDY) ? {3'b000, dir, 1'b0} : {4'b0000, dir};

	//##########################################################
	// game rules
	//##########################################################
	always_comb
	begin
		// adc idle at mid scale, buttons released
		sw_nxt = 5'b11111;
		b7_nxt = 8'hFF;
		b6_nxt = 8'h00;
		case (game_type)
		MARBLE:
			sw_nxt = {3'b111, ~a0, ~a1};
		INDY:
		begin
			// on/off style
			b7_nxt = inputs;
			b6_nxt = inputs;
			sw_nxt = {3'b111, ~a0, ~a1};
		end
		PETERPAK:
		begin
			b7_nxt = inputs;
			b6_nxt = inputs;
			// jump on sw3, throw on sw1
			sw_nxt = {2'b11, ~a0, 1'b1, ~a1};
		end
		ROADRUN:
		begin
			sw_nxt = {3'b111, ~a0, ~a1};
			// tristate, 11 full on, 00 full off, 10 centre
			if (dir[2])
				{b7_nxt[7], b6_nxt[7]} = 2'b11;
			else if (dir[3])
				{b7_nxt[7], b6_nxt[7]} = 2'b00;
			if (dir[0])
				{b7_nxt[0], b6_nxt[0]} = 2'b00;
			else if (dir[1])
				{b7_nxt[0], b6_nxt[0]} = 2'b11;
		end
		ROADB109, ROADB110:
		begin
			// fire only, throttle on adc bit 3
			sw_nxt = {3'b111, ~a0, 1'b1};
			b7_nxt[3] = 1'b0;
			b6_nxt[3] = a1;
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			switches <= 5'b11111;
			coin_n <= 3'b111;
			selftest_n <= 1'b1;
			adc_bit7 <= 8'hFF;
			adc_bit6 <= 8'h00;
		end
		else
		begin
			switches <= sw_nxt;
			// aux, right, left
			coin_n <= {~keys.coin_aux, ~keys.coin_r, ~(keys.coin_l | joystick[8])};
			selftest_n <= ~service;
			adc_bit7 <= b7_nxt;
			adc_bit6 <= b6_nxt;
		end
	end

	// sw5 and sw4 are not wired on any cabinet
	a_sw_unused_high: assert property (@(posedge clk_sys) disable iff (!arst_n)
		switches[4:3] == 2'b11)
		else $error("switches[4:3] driven low for game %0d", game_type);

endmodule

//--- verilog/sys1_io_top.sv
//##########################################################
// system-1 input side top level
// rom router, game register, keyboard and control mapper
//##########################################################
`timescale 1ns/1ns
`include "sys1_settings.svh"

module sys1_io_top
(
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// download bus
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  logic [7:0]                ioctl_index,
	input  logic [`SYS1_ADDR_W-1:0]   ioctl_addr,
	input  logic [7:0]                ioctl_dout,
	output logic                      ioctl_wait,
	// rom write requests
	input  logic                      rom_ready,
	output logic                      rom_wr,
	output sys1_rom_pkg::rom_region_e rom_region,
	output sys1_rom_pkg::rom_addr_t   rom_addr,
	output sys1_rom_pkg::rom_word_t   rom_data,
	// player inputs
	input  logic [10:0]               ps2_key,
	input  logic [11:0]               joystick,
	input  logic                      service,
	// cabinet side
	output logic [4:0]                switches,
	output logic [2:0]                coin_n,
	output logic                      selftest_n,
	output logic [7:0]                adc_bit7,
	output logic [7:0]                adc_bit6,
	output sys1_ctrl_pkg::game_e      game_type
);
	import sys1_ctrl_pkg::*;

	key_state_t keys;

	rom_loader rom_loader_inst
	(
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_ready      (rom_ready),
		.ioctl_wait     (ioctl_wait),
		.rom_wr         (rom_wr),
		.rom_region     (rom_region),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data)
	);

	// steers the mapper below
	game_config game_config_inst
	(
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_dout     (ioctl_dout),
		.game_type      (game_type)
	);

	ps2_key_decoder ps2_key_decoder_inst
	(
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	control_mapper control_mapper_inst
	(
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.game_type  (game_type),
		.keys       (keys),
		.joystick   (joystick),
		.service    (service),
		.switches   (switches),
		.coin_n     (coin_n),
		.selftest_n (selftest_n),
		.adc_bit7   (adc_bit7),
		.adc_bit6   (adc_bit6)
	);

endmodule

//--- bench/tb_sys1_io.sv
//##########################################################
// directed testbench for the system-1 input side
// clock, reset, lfsr bytes, download and control tests
//##########################################################
`timescale 1ns/1ns
`include "sys1_settings.svh"

module tb_sys1_io;
	import sys1_rom_pkg::*;
	import sys1_ctrl_pkg::*;

	localparam int WAIT_LIMIT = 50;

	logic                    clk_sys;
	logic                    arst_n;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [7:0]              ioctl_index;
	logic [`SYS1_ADDR_W-1:0] ioctl_addr;
	logic [7:0]              ioctl_dout;
	logic                    ioctl_wait;
	logic                    rom_ready;
	logic                    rom_wr;
	rom_region_e             rom_region;
	rom_addr_t               rom_addr;
	rom_word_t               rom_data;
	logic [10:0]             ps2_key;
	logic [11:0]             joystick;
	logic                    service;
	logic [4:0]              switches;
	logic [2:0]              coin_n;
	logic                    selftest_n;
	logic [7:0]              adc_bit7;
	logic [7:0]              adc_bit6;
	game_e                   game_type;

	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          wr_count = 0;
	logic [31:0] lfsr = 32'h7c9;
	logic        ps2_toggle = 1'b0;
	rom_region_e cap_region;
	rom_addr_t   cap_addr;
	rom_word_t   cap_data;

	sys1_io_top sys1_io_top_inst
	(
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.rom_ready      (rom_ready),
		.rom_wr         (rom_wr),
		.rom_region     (rom_region),
		.rom_addr       (rom_addr),
		.rom_data       (rom_data),
		.ps2_key        (ps2_key),
		.joystick       (joystick),
		.service        (service),
		.switches       (switches),
		.coin_n         (coin_n),
		.selftest_n     (selftest_n),
		.adc_bit7       (adc_bit7),
		.adc_bit6       (adc_bit6),
		.game_type      (game_type)
	);

	// 100 ns period
	initial
	begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// capture each write strobe mid cycle, outputs are settled here
	always @(negedge clk_sys)
	begin
		if (rom_wr === 1'b1)
		begin
			wr_count = wr_count + 1;
			cap_region = rom_region;
			cap_addr = rom_addr;
			cap_data = rom_data;
		end
	end

	//##########################################################
	// helpers
	//##########################################################
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic next_byte(output logic [7:0] b);
		b = 8'h00;
		for (int k = 0; k < 8; k++)
		begin
			b = {b[6:0], lfsr[31]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic check_region(input string name, input rom_region_e got, input rom_region_e exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input rom_word_t got, input rom_word_t exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_game(input string name, input game_e got, input game_e exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bits(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test failures found");
		$finish;
	endtask

	task automatic report_test(input string name, input int e0);
		tests_run++;
		if (errors == e0)
			$display("test %s ok", name);
		else
		begin
			tests_failed++;
			$display("test %s FAILED with %0d errors", name, errors - e0);
		end
	endtask

	// one download byte, only once the router stops stalling
	task automatic send_byte(input logic [7:0] idx, input logic [`SYS1_ADDR_W-1:0] addr,
		input logic [7:0] data);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (ioctl_wait && n < WAIT_LIMIT)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (ioctl_wait)
			abort_on_timeout("ioctl_wait to drop");
		else
		begin
			@(posedge clk_sys);
			ioctl_download <= 1'b1;
			ioctl_wr <= 1'b1;
			ioctl_index <= idx;
			ioctl_addr <= addr;
			ioctl_dout <= data;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			ioctl_download <= 1'b0;
		end
	endtask

	// count strobes, then a few quiet cycles for strays
	task automatic wait_writes(input int count);
		int n;
		n = 0;
		@(posedge clk_sys);
		while (wr_count < count && n < WAIT_LIMIT)
		begin
			@(posedge clk_sys);
			n++;
		end
		if (wr_count < count)
			abort_on_timeout("rom_wr");
		else
			repeat (3) @(posedge clk_sys);
	endtask

	// bit 10 flips per event
	task automatic key_event(input logic [8:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_toggle = ~ps2_toggle;
		ps2_key <= {ps2_toggle, pressed, code};
	endtask

	task automatic set_joystick(input logic [11:0] value);
		@(posedge clk_sys);
		joystick <= value;
	endtask

	// fixed pipeline depth, then sample mid cycle
	task automatic settle(input int cycles);
		repeat (cycles) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	//##########################################################
	// tests
	//##########################################################
	task automatic test_reset_values();
		int e0;
		e0 = errors;
		check_game("game_type", game_type, INDY);
		check_bits("switches", {3'b000, switches}, 8'h1F);
		check_bits("coin_n", {5'b00000, coin_n}, 8'h07);
		check_bits("adc_bit7", adc_bit7, 8'hFF);
		check_bits("adc_bit6", adc_bit6, 8'h00);
		check_bits("rom_wr", {7'd0, rom_wr}, 8'h00);
		report_test("reset values", e0);
	endtask

	task automatic test_rom_download();
		int         e0;
		logic [7:0] b [8];
		rom_word_t  exp_word;
		e0 = errors;
		// gfx word 1, first byte lands in the top lane
		wr_count = 0;
		exp_word = '0;
		for (int i = 0; i < 8; i++)
		begin
			next_byte(b[i]);
			exp_word = {exp_word[55:0], b[i]};
			send_byte(8'd0, 25'(8 + i), b[i]);
		end
		wait_writes(1);
		check_bits("rom_wr count", 8'(wr_count), 8'd1);
		check_region("rom_region", cap_region, GFX);
		check_addr("rom_addr", cap_addr, 19'd1);
		check_word("rom_data", cap_data, exp_word);
		// program word, high byte at the even address
		wr_count = 0;
		next_byte(b[0]);
		next_byte(b[1]);
		send_byte(8'd0, 25'h400000, b[0]);
		send_byte(8'd0, 25'h400001, b[1]);
		wait_writes(1);
		check_bits("rom_wr count", 8'(wr_count), 8'd1);
		check_region("rom_region", cap_region, PROG0);
		check_addr("rom_addr", cap_addr, 19'd0);
		check_word("rom_data", cap_data, {48'd0, b[0], b[1]});
		// remap prom, one byte per write
		wr_count = 0;
		next_byte(b[2]);
		send_byte(8'd0, 25'h498201, b[2]);
		wait_writes(1);
		check_bits("rom_wr count", 8'(wr_count), 8'd1);
		check_region("rom_region", cap_region, REMAP);
		check_addr("rom_addr", cap_addr, 19'd1);
		check_word("rom_data", cap_data, {56'd0, b[2]});
		report_test("rom download", e0);
	endtask

	task automatic test_back_pressure();
		int         e0;
		logic [7:0] b;
		e0 = errors;
		wr_count = 0;
		next_byte(b);
		@(posedge clk_sys);
		rom_ready <= 1'b0;
		fork
			// host holds its byte until ioctl_wait drops
			send_byte(8'd0, 25'h488005, b);
			begin
				// sink stalled, nothing may get through
				repeat (3)
				begin
					@(negedge clk_sys);
					check_bits("ioctl_wait", {7'd0, ioctl_wait}, 8'h01);
					check_bits("rom_wr", {7'd0, rom_wr}, 8'h00);
				end
				@(posedge clk_sys);
				rom_ready <= 1'b1;
			end
		join
		wait_writes(1);
		check_bits("rom_wr count", 8'(wr_count), 8'd1);
		check_region("rom_region", cap_region, SND0);
		check_addr("rom_addr", cap_addr, 19'd5);
		check_word("rom_data", cap_data, {56'd0, b});
		report_test("back pressure", e0);
	endtask

	task automatic test_roadrun_keys();
		int e0;
		e0 = errors;
		send_byte(8'd1, '0, 8'd108);
		settle(0);
		check_game("game_type", game_type, ROADRUN);
		// down sets bit 7 of both bytes
		key_event(9'h172, 1'b1);
		settle(2);
		check_bits("adc_bit7", adc_bit7, 8'hFF);
		check_bits("adc_bit6", adc_bit6, 8'h80);
		key_event(9'h172, 1'b0);
		// left sets bit 0 of both bytes
		key_event(9'h16B, 1'b1);
		settle(2);
		check_bits("adc_bit7", adc_bit7, 8'hFF);
		check_bits("adc_bit6", adc_bit6, 8'h01);
		key_event(9'h16B, 1'b0);
		settle(2);
		check_bits("adc_bit6", adc_bit6, 8'h00);
		report_test("roadrun keys", e0);
	endtask

	task automatic test_game_switches();
		int e0;
		e0 = errors;
		// peterpak jump on bit 2
		send_byte(8'd1, '0, 8'd107);
		set_joystick(12'h010);
		settle(1);
		check_bits("switches", {3'b000, switches}, 8'h1B);
		// road blasters throttle on adc bit 3
		send_byte(8'd1, '0, 8'd110);
		set_joystick(12'h020);
		settle(1);
		check_bits("switches", {3'b000, switches}, 8'h1F);
		check_bits("adc_bit7", adc_bit7, 8'hF7);
		check_bits("adc_bit6", adc_bit6, 8'h08);
		// indy up, shifted left by one
		send_byte(8'd1, '0, 8'd105);
		set_joystick(12'h008);
		settle(1);
		check_bits("adc_bit7", adc_bit7, 8'h10);
		check_bits("adc_bit6", adc_bit6, 8'h10);
		set_joystick(12'h000);
		report_test("game switches", e0);
	endtask

	task automatic test_coins_service();
		int e0;
		e0 = errors;
		key_event(9'h02E, 1'b1);
		settle(2);
		check_bits("coin_n", {5'b00000, coin_n}, 8'h06);
		key_event(9'h02E, 1'b0);
		settle(2);
		check_bits("coin_n", {5'b00000, coin_n}, 8'h07);
		set_joystick(12'h100);
		settle(1);
		check_bits("coin_n", {5'b00000, coin_n}, 8'h06);
		set_joystick(12'h000);
		@(posedge clk_sys);
		service <= 1'b1;
		settle(1);
		check_bits("selftest_n", {7'd0, selftest_n}, 8'h00);
		@(posedge clk_sys);
		service <= 1'b0;
		report_test("coins service", e0);
	endtask

	//##########################################################
	// main sequence
	//##########################################################
	initial
	begin
		arst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		rom_ready = 1'b1;
		ps2_key = 11'd0;
		joystick = 12'd0;
		service = 1'b0;
		repeat (4) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		test_reset_values();
		test_rom_download();
		test_back_pressure();
		test_roadrun_keys();
		test_game_switches();
		test_coins_service();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- list.f
+incdir+include
verilog/sys1_rom_pkg.sv
verilog/sys1_ctrl_pkg.sv
verilog/rom_loader.sv
verilog/game_config.sv
verilog/ps2_key_decoder.sv
verilog/control_mapper.sv
verilog/sys1_io_top.sv
bench/tb_sys1_io.sv

//--- Bender.yml
package:
  name: sys1_io

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/sys1_rom_pkg.sv
      - verilog/sys1_ctrl_pkg.sv
      - verilog/rom_loader.sv
      - verilog/game_config.sv
      - verilog/ps2_key_decoder.sv
      - verilog/control_mapper.sv
      - verilog/sys1_io_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_sys1_io.sv
